//--- verilog/simd_pkg.sv
// shared types and constants for the packed-SIMD execution slice
// data and bus-word types, opcodes, lane function codes, status codes
package simd_pkg;

  localparam int DATA_W = 64;
  // default bypass bus count, overridden from the top level
  localparam int NUM_FWD = 4;

  typedef logic [DATA_W-1:0] data_t;
  // parity bit above the data, even over all 65 bits
  typedef logic [DATA_W:0] bus_word_t;
  typedef logic [3:0] op_t;
  typedef logic [2:0] alu_fn_t;
  typedef logic [1:0] perm_fn_t;
  typedef logic [1:0] ret_t;
  // 0 is the register operand, k is bypass bus k-1
  typedef logic [2:0] fwd_sel_t;

  localparam op_t OP_ADD32   = 4'd0;
  localparam op_t OP_SUB32   = 4'd1;
  localparam op_t OP_ADD16   = 4'd2;
  localparam op_t OP_SUB16   = 4'd3;
  localparam op_t OP_AND     = 4'd4;
  localparam op_t OP_OR      = 4'd5;
  localparam op_t OP_XOR     = 4'd6;
  localparam op_t OP_ANDN    = 4'd7;
  localparam op_t OP_SWAP    = 4'd8;
  localparam op_t OP_DUP_LO  = 4'd9;
  localparam op_t OP_DUP_HI  = 4'd10;
  localparam op_t OP_PASS_B  = 4'd11;

  localparam alu_fn_t ALU_ADD32 = 3'd0;
  localparam alu_fn_t ALU_SUB32 = 3'd1;
  localparam alu_fn_t ALU_ADD16 = 3'd2;
  localparam alu_fn_t ALU_SUB16 = 3'd3;
  localparam alu_fn_t ALU_AND   = 3'd4;
  localparam alu_fn_t ALU_OR    = 3'd5;
  localparam alu_fn_t ALU_XOR   = 3'd6;
  localparam alu_fn_t ALU_ANDN  = 3'd7;

  localparam perm_fn_t PERM_SWAP   = 2'd0;
  localparam perm_fn_t PERM_DUP_LO = 2'd1;
  localparam perm_fn_t PERM_DUP_HI = 2'd2;
  localparam perm_fn_t PERM_PASS_B = 2'd3;

  localparam ret_t RET_OK      = 2'd0;
  localparam ret_t RET_PARITY  = 2'd1;
  localparam ret_t RET_ILLEGAL = 2'd2;

endpackage

//--- verilog/operand_forward.sv
`timescale 1ns/1ps
// operand source select for one execution-unit operand
// register operand or one of the bypass buses, current or one cycle old
// registered data word and even-parity check of the selected word
module operand_forward import simd_pkg::*; #(
  parameter int NUM_FWD = simd_pkg::NUM_FWD
) (
  input  logic                     clk,
  input  logic                     rst,
  input  bus_word_t                opnd,
  input  bus_word_t [NUM_FWD-1:0]  fwd_bus,
  input  fwd_sel_t                 sel,
  input  logic                     late,
  output data_t                    word,
  output logic                     err
);

  bus_word_t [NUM_FWD-1:0] fwd_prev;
  bus_word_t               sel_word;

  // one-cycle history of every bypass bus
  always_ff @(posedge clk) begin
    fwd_prev <= fwd_bus;
  end

  // late consumers take last cycle's bus value
  always_comb begin
    sel_word = opnd;
    for (int k = 0; k < NUM_FWD; k++) begin
      if (sel == fwd_sel_t'(k + 1)) begin
        sel_word = late ? fwd_prev[k] : fwd_bus[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      err <= 1'b0;
    end else begin
      // even parity, any odd word is an error
      err <= ^sel_word;
    end
    word <= sel_word[DATA_W-1:0];
  end

  // bypass index must name an existing bus
  a_sel_range: assert property (
    @(posedge clk) disable iff (rst) sel <= NUM_FWD
  );

endmodule

//--- verilog/op_decode.sv
`timescale 1ns/1ps
// opcode decode for the SIMD slice
// picks the ALU or permute lane and that lane's function, or flags illegal
module op_decode import simd_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     issue,
  input  op_t      op,
  output logic     valid_alu,
  output logic     valid_perm,
  output logic     illegal,
  output alu_fn_t  alu_fn,
  output perm_fn_t perm_fn
);

  logic     is_alu;
  logic     is_perm;
  alu_fn_t  alu_fn_d;
  perm_fn_t perm_fn_d;

  always_comb begin
    is_alu = 1'b0;
    is_perm = 1'b0;
    alu_fn_d = ALU_ADD32;
    perm_fn_d = PERM_PASS_B;
    case (op)
      OP_ADD32: alu_fn_d = ALU_ADD32;
      OP_SUB32: alu_fn_d = ALU_SUB32;
      OP_ADD16: alu_fn_d = ALU_ADD16;
      OP_SUB16: alu_fn_d = ALU_SUB16;
      OP_AND:   alu_fn_d = ALU_AND;
      OP_OR:    alu_fn_d = ALU_OR;
      OP_XOR:   alu_fn_d = ALU_XOR;
      OP_ANDN:  alu_fn_d = ALU_ANDN;
      OP_SWAP:   perm_fn_d = PERM_SWAP;
      OP_DUP_LO: perm_fn_d = PERM_DUP_LO;
      OP_DUP_HI: perm_fn_d = PERM_DUP_HI;
      OP_PASS_B: perm_fn_d = PERM_PASS_B;
      default: ;
    endcase
    case (op)
      OP_ADD32, OP_SUB32, OP_ADD16, OP_SUB16,
      OP_AND, OP_OR, OP_XOR, OP_ANDN: is_alu = 1'b1;
      OP_SWAP, OP_DUP_LO, OP_DUP_HI, OP_PASS_B: is_perm = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_alu <= 1'b0;
      valid_perm <= 1'b0;
      illegal <= 1'b0;
    end else begin
      valid_alu <= issue & is_alu;
      valid_perm <= issue & is_perm;
      // the four spare codes
      illegal <= issue & (op > OP_PASS_B);
    end
    alu_fn <= alu_fn_d;
    perm_fn <= perm_fn_d;
  end

  a_one_lane: assert property (
    @(posedge clk) disable iff (rst) $onehot0({valid_alu, valid_perm, illegal})
  );

endmodule

//--- verilog/simd_alu_lane.sv
`timescale 1ns/1ps
// packed integer ALU lane
// 2x32 or 4x16 add and subtract without carry between lanes
// bitwise and, or, xor, and-not, one registered stage
module simd_alu_lane import simd_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    valid_in,
  input  alu_fn_t fn,
  input  data_t   a,
  input  data_t   b,
  output data_t   result,
  output logic    valid
);

  data_t res_d;

  // each slice wraps at its own width
  always_comb begin
    res_d = '0;
    case (fn)
      ALU_ADD32: begin
        for (int i = 0; i < 2; i++) begin
          res_d[32*i +: 32] = a[32*i +: 32] + b[32*i +: 32];
        end
      end
      ALU_SUB32: begin
        for (int i = 0; i < 2; i++) begin
          res_d[32*i +: 32] = a[32*i +: 32] - b[32*i +: 32];
        end
      end
      ALU_ADD16: begin
        for (int i = 0; i < 4; i++) begin
          res_d[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
        end
      end
      ALU_SUB16: begin
        for (int i = 0; i < 4; i++) begin
          res_d[16*i +: 16] = a[16*i +: 16] - b[16*i +: 16];
        end
      end
      ALU_AND:  res_d = a & b;
      ALU_OR:   res_d = a | b;
      ALU_XOR:  res_d = a ^ b;
      ALU_ANDN: res_d = a & ~b;
      default:  res_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= valid_in;
    end
    result <= res_d;
  end

endmodule

//--- verilog/permute_lane.sv
`timescale 1ns/1ps
// permute lane
// swaps or duplicates the 32-bit halves of A, or passes B
module permute_lane import simd_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_in,
  input  perm_fn_t fn,
  input  data_t    a,
  input  data_t    b,
  output data_t    result,
  output logic     valid
);

  data_t res_d;

  always_comb begin
    case (fn)
      PERM_SWAP:   res_d = {a[31:0], a[63:32]};
      PERM_DUP_LO: res_d = {a[31:0], a[31:0]};
      PERM_DUP_HI: res_d = {a[63:32], a[63:32]};
      PERM_PASS_B: res_d = b;
      default:     res_d = b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else begin
      valid <= valid_in;
    end
    result <= res_d;
  end

endmodule

//--- verilog/result_bus_arbiter.sv
`timescale 1ns/1ps
// result bus owner for the SIMD slice
// fixed priority alt0, alt1, ALU lane, permute lane
// parity generation for lane results and the per-op status return
module result_bus_arbiter import simd_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic [1:0] alt_sel,
  input  bus_word_t alt_data0,
  input  bus_word_t alt_data1,
  input  data_t     alu_result,
  input  logic      alu_valid,
  input  data_t     perm_result,
  input  logic      perm_valid,
  input  logic      err_a,
  input  logic      err_b,
  input  logic      illegal,
  input  logic      issued,
  output bus_word_t bus_word,
  output logic      bus_valid,
  output ret_t      ret,
  output logic      ret_en
);

  bus_word_t lane_word;
  logic      err_q;
  logic      illegal_q;
  logic      issued_q;

  // even parity bit on top of the lane data
  always_comb begin
    if (alu_valid) begin
      lane_word = {^alu_result, alu_result};
    end else begin
      lane_word = {^perm_result, perm_result};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_valid <= 1'b0;
      issued_q <= 1'b0;
      ret_en <= 1'b0;
    end else begin
      bus_valid <= (|alt_sel) | alu_valid | perm_valid;
      issued_q <= issued;
      ret_en <= issued_q;
    end
    // alternate words go out as they are and drop a colliding lane result
    if (alt_sel[0]) begin
      bus_word <= alt_data0;
    end else if (alt_sel[1]) begin
      bus_word <= alt_data1;
    end else begin
      bus_word <= lane_word;
    end
    // status stage lines up with the lane stage
    err_q <= err_a | err_b;
    illegal_q <= illegal;
    if (err_q) begin
      ret <= RET_PARITY;
    end else if (illegal_q) begin
      ret <= RET_ILLEGAL;
    end else begin
      ret <= RET_OK;
    end
  end

  a_one_lane_result: assert property (
    @(posedge clk) disable iff (rst) !(alu_valid && perm_valid)
  );

  a_alt_sel_legal: assert property (
    @(posedge clk) disable iff (rst) alt_sel != 2'b11
  );

endmodule

//--- verilog/simd_unit.sv
`timescale 1ns/1ps
// packed-SIMD execution slice, top level
// operand forwarding, decode, ALU and permute lanes, result bus arbiter
module simd_unit import simd_pkg::*; #(
  parameter int NUM_FWD = simd_pkg::NUM_FWD
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue,
  input  op_t                     op,
  input  bus_word_t               opnd_a,
  input  bus_word_t               opnd_b,
  input  bus_word_t [NUM_FWD-1:0] fwd_bus,
  input  fwd_sel_t                sel_a,
  input  fwd_sel_t                sel_b,
  input  logic                    late_a,
  input  logic                    late_b,
  input  logic [1:0]              alt_sel,
  input  bus_word_t               alt_data0,
  input  bus_word_t               alt_data1,
  output bus_word_t               bus_word,
  output logic                    bus_valid,
  output ret_t                    ret,
  output logic                    ret_en
);

  data_t    a_word;
  data_t    b_word;
  logic     err_a;
  logic     err_b;
  logic     dec_valid_alu;
  logic     dec_valid_perm;
  logic     dec_illegal;
  alu_fn_t  dec_alu_fn;
  perm_fn_t dec_perm_fn;
  data_t    alu_result;
  logic     alu_valid;
  data_t    perm_result;
  logic     perm_valid;

  operand_forward #(.NUM_FWD(NUM_FWD)) u_fwd_a (
    .clk(clk), .rst(rst), .opnd(opnd_a), .fwd_bus(fwd_bus),
    .sel(sel_a), .late(late_a), .word(a_word), .err(err_a)
  );

  operand_forward #(.NUM_FWD(NUM_FWD)) u_fwd_b (
    .clk(clk), .rst(rst), .opnd(opnd_b), .fwd_bus(fwd_bus),
    .sel(sel_b), .late(late_b), .word(b_word), .err(err_b)
  );

  op_decode u_op_decode (
    .clk(clk), .rst(rst), .issue(issue), .op(op),
    .valid_alu(dec_valid_alu), .valid_perm(dec_valid_perm), .illegal(dec_illegal),
    .alu_fn(dec_alu_fn), .perm_fn(dec_perm_fn)
  );

  simd_alu_lane u_alu_lane (
    .clk(clk), .rst(rst), .valid_in(dec_valid_alu), .fn(dec_alu_fn),
    .a(a_word), .b(b_word), .result(alu_result), .valid(alu_valid)
  );

  permute_lane u_permute_lane (
    .clk(clk), .rst(rst), .valid_in(dec_valid_perm), .fn(dec_perm_fn),
    .a(a_word), .b(b_word), .result(perm_result), .valid(perm_valid)
  );

  // every registered issue, legal or not, returns a status
  result_bus_arbiter u_arbiter (
    .clk(clk), .rst(rst), .alt_sel(alt_sel),
    .alt_data0(alt_data0), .alt_data1(alt_data1),
    .alu_result(alu_result), .alu_valid(alu_valid),
    .perm_result(perm_result), .perm_valid(perm_valid),
    .err_a(err_a), .err_b(err_b), .illegal(dec_illegal),
    .issued(dec_valid_alu | dec_valid_perm | dec_illegal),
    .bus_word(bus_word), .bus_valid(bus_valid), .ret(ret), .ret_en(ret_en)
  );

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps
// testbench clock and reset generator
// free-running clock, reset held high for the first few cycles
module tb_clock #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- dv/simd_unit_tb.sv
`timescale 1ns/1ps
// directed testbench for the packed-SIMD execution slice
// reference model, Galois LFSR stimulus, compare tasks, watchdog
module simd_unit_tb import simd_pkg::*; #(
  parameter int NUM_FWD = simd_pkg::NUM_FWD
);

  // ALU 10, permute 4, status 7, collisions 2, back-to-back 6, forwarding 2 per bus
  localparam int NUM_OPS = 29 + 2 * NUM_FWD;
  localparam int MAX_CYCLES = 200 + 10 * NUM_OPS;

  logic                    clk;
  logic                    rst;
  logic                    issue;
  op_t                     op;
  bus_word_t               opnd_a;
  bus_word_t               opnd_b;
  bus_word_t [NUM_FWD-1:0] fwd_bus;
  fwd_sel_t                sel_a;
  fwd_sel_t                sel_b;
  logic                    late_a;
  logic                    late_b;
  logic [1:0]              alt_sel;
  bus_word_t               alt_data0;
  bus_word_t               alt_data1;
  bus_word_t               bus_word;
  logic                    bus_valid;
  ret_t                    ret;
  logic                    ret_en;
  logic [31:0]             lfsr_state = 32'd73756;

  tb_clock #(.PERIOD_NS(8.0), .RST_CYCLES(2)) u_tb_clock (.clk(clk), .rst(rst));

  simd_unit #(.NUM_FWD(NUM_FWD)) u_simd_unit (
    .clk(clk), .rst(rst), .issue(issue), .op(op), .opnd_a(opnd_a), .opnd_b(opnd_b),
    .fwd_bus(fwd_bus), .sel_a(sel_a), .sel_b(sel_b), .late_a(late_a), .late_b(late_b),
    .alt_sel(alt_sel), .alt_data0(alt_data0), .alt_data1(alt_data1),
    .bus_word(bus_word), .bus_valid(bus_valid), .ret(ret), .ret_en(ret_en)
  );

  // taps 32, 22, 2, 1
  function automatic logic next_rand_bit();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out_bit;
  endfunction

  function automatic bus_word_t rand_bits(int n);
    bus_word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = next_rand_bit();
    end
    return v;
  endfunction

  function automatic bus_word_t add_parity(data_t d);
    return {^d, d};
  endfunction

  function automatic bus_word_t bad_parity(data_t d);
    return {~(^d), d};
  endfunction

  function automatic data_t expected_result(op_t o, data_t a, data_t b);
    case (o)
      OP_ADD32:  return {a[63:32] + b[63:32], a[31:0] + b[31:0]};
      OP_SUB32:  return {a[63:32] - b[63:32], a[31:0] - b[31:0]};
      OP_ADD16:  return {a[63:48] + b[63:48], a[47:32] + b[47:32],
                         a[31:16] + b[31:16], a[15:0] + b[15:0]};
      OP_SUB16:  return {a[63:48] - b[63:48], a[47:32] - b[47:32],
                         a[31:16] - b[31:16], a[15:0] - b[15:0]};
      OP_AND:    return a & b;
      OP_OR:     return a | b;
      OP_XOR:    return a ^ b;
      OP_ANDN:   return a & ~b;
      OP_SWAP:   return {a[31:0], a[63:32]};
      OP_DUP_LO: return {a[31:0], a[31:0]};
      OP_DUP_HI: return {a[63:32], a[63:32]};
      OP_PASS_B: return b;
      default:   return '0;
    endcase
  endfunction

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(bus_word_t got, bus_word_t exp, string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_ret(ret_t got, ret_t exp, string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_run();
    end
  endtask

  // one op from register operands, returns at the result cycle
  task automatic issue_op(op_t o, bus_word_t a, bus_word_t b);
    @(posedge clk);
    issue <= 1'b1;
    op <= o;
    opnd_a <= a;
    opnd_b <= b;
    @(posedge clk);
    issue <= 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic check_op_result(op_t o, data_t a, data_t b);
    if (o > OP_PASS_B) begin
      check_flag(bus_valid, 1'b0, "bus_valid for illegal op");
      check_ret(ret, RET_ILLEGAL, "ret for illegal op");
    end else begin
      check_flag(bus_valid, 1'b1, "bus_valid");
      check_word(bus_word, add_parity(expected_result(o, a, b)), "bus_word");
      check_ret(ret, RET_OK, "ret");
    end
    check_flag(ret_en, 1'b1, "ret_en");
  endtask

  task automatic alu_test();
    data_t a;
    data_t b;
    for (int o = 0; o < 8; o++) begin
      a = data_t'(rand_bits(DATA_W));
      b = data_t'(rand_bits(DATA_W));
      issue_op(op_t'(o), add_parity(a), add_parity(b));
      check_op_result(op_t'(o), a, b);
    end
    // carries and borrows stop at lane edges
    a = 64'h0000_0001_ffff_ffff;
    b = 64'h0000_ffff_0000_0001;
    issue_op(OP_ADD32, add_parity(a), add_parity(b));
    check_op_result(OP_ADD32, a, b);
    a = 64'h0000_8000_ffff_0000;
    b = 64'h0001_8000_0001_0001;
    issue_op(OP_SUB16, add_parity(a), add_parity(b));
    check_op_result(OP_SUB16, a, b);
  endtask

  task automatic permute_test();
    data_t a;
    data_t b;
    for (int o = 8; o < 12; o++) begin
      a = data_t'(rand_bits(DATA_W));
      b = data_t'(rand_bits(DATA_W));
      issue_op(op_t'(o), add_parity(a), add_parity(b));
      check_op_result(op_t'(o), a, b);
    end
  endtask

  task automatic forwarding_test();
    bus_word_t prev_bus [NUM_FWD];
    bus_word_t cur_bus [NUM_FWD];
    data_t     exp_a;
    data_t     exp_b;
    int        kb;
    for (int k = 0; k < NUM_FWD; k++) begin
      for (int l = 0; l < 2; l++) begin
        kb = (k + 1) % NUM_FWD;
        @(posedge clk);
        for (int i = 0; i < NUM_FWD; i++) begin
          prev_bus[i] = add_parity(data_t'(rand_bits(DATA_W)));
          fwd_bus[i] <= prev_bus[i];
        end
        @(posedge clk);
        for (int i = 0; i < NUM_FWD; i++) begin
          cur_bus[i] = add_parity(data_t'(rand_bits(DATA_W)));
          fwd_bus[i] <= cur_bus[i];
        end
        issue <= 1'b1;
        op <= OP_SUB32;
        sel_a <= fwd_sel_t'(k + 1);
        sel_b <= fwd_sel_t'(kb + 1);
        late_a <= (l == 1);
        late_b <= (l == 0);
        if (l == 1) begin
          exp_a = prev_bus[k][DATA_W-1:0];
          exp_b = cur_bus[kb][DATA_W-1:0];
        end else begin
          exp_a = cur_bus[k][DATA_W-1:0];
          exp_b = prev_bus[kb][DATA_W-1:0];
        end
        @(posedge clk);
        issue <= 1'b0;
        sel_a <= '0;
        sel_b <= '0;
        late_a <= 1'b0;
        late_b <= 1'b0;
        for (int i = 0; i < NUM_FWD; i++) begin
          fwd_bus[i] <= add_parity(data_t'(rand_bits(DATA_W)));
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_op_result(OP_SUB32, exp_a, exp_b);
      end
    end
  endtask

  task automatic status_test();
    data_t a;
    data_t b;
    a = data_t'(rand_bits(DATA_W));
    b = data_t'(rand_bits(DATA_W));
    issue_op(OP_ADD32, bad_parity(a), add_parity(b));
    check_flag(ret_en, 1'b1, "ret_en for bad A");
    check_ret(ret, RET_PARITY, "ret for bad A");
    issue_op(OP_SWAP, add_parity(a), bad_parity(b));
    check_flag(ret_en, 1'b1, "ret_en for bad B");
    check_ret(ret, RET_PARITY, "ret for bad B");
    for (int o = 12; o < 16; o++) begin
      issue_op(op_t'(o), add_parity(a), add_parity(b));
      check_op_result(op_t'(o), a, b);
    end
    // parity outranks illegal
    issue_op(op_t'(13), bad_parity(a), add_parity(b));
    check_flag(bus_valid, 1'b0, "bus_valid for bad illegal op");
    check_ret(ret, RET_PARITY, "ret for bad illegal op");
  endtask

  task automatic priority_test();
    bus_word_t w0;
    bus_word_t w1;
    data_t     a;
    data_t     b;
    for (int s = 1; s < 3; s++) begin
      w0 = rand_bits(DATA_W + 1);
      w1 = rand_bits(DATA_W + 1);
      @(posedge clk);
      alt_sel <= 2'(s);
      alt_data0 <= w0;
      alt_data1 <= w1;
      @(posedge clk);
      alt_sel <= 2'b00;
      @(negedge clk);
      check_flag(bus_valid, 1'b1, "bus_valid for alternate word");
      check_word(bus_word, (s == 1) ? w0 : w1, "alternate bus_word");
      check_flag(ret_en, 1'b0, "ret_en without op");
    end
    // alternate word lands in the lane result cycle
    for (int s = 1; s < 3; s++) begin
      a = data_t'(rand_bits(DATA_W));
      b = data_t'(rand_bits(DATA_W));
      w0 = rand_bits(DATA_W + 1);
      w1 = rand_bits(DATA_W + 1);
      @(posedge clk);
      issue <= 1'b1;
      op <= OP_XOR;
      opnd_a <= add_parity(a);
      opnd_b <= add_parity(b);
      @(posedge clk);
      issue <= 1'b0;
      @(posedge clk);
      alt_sel <= 2'(s);
      alt_data0 <= w0;
      alt_data1 <= w1;
      @(posedge clk);
      alt_sel <= 2'b00;
      @(negedge clk);
      check_flag(bus_valid, 1'b1, "bus_valid in collision");
      check_word(bus_word, (s == 1) ? w0 : w1, "bus_word in collision");
      check_flag(ret_en, 1'b1, "ret_en in collision");
      check_ret(ret, RET_OK, "ret in collision");
      @(negedge clk);
      check_flag(bus_valid, 1'b0, "bus_valid after collision");
    end
  endtask

  task automatic back_to_back_test();
    op_t   ops [6];
    data_t av [6];
    data_t bv [6];
    ops = '{OP_ADD16, OP_DUP_HI, OP_SUB32, op_t'(14), OP_ANDN, OP_PASS_B};
    for (int i = 0; i < 6; i++) begin
      av[i] = data_t'(rand_bits(DATA_W));
      bv[i] = data_t'(rand_bits(DATA_W));
    end
    for (int j = 0; j < 9; j++) begin
      @(posedge clk);
      if (j < 6) begin
        issue <= 1'b1;
        op <= ops[j];
        opnd_a <= add_parity(av[j]);
        opnd_b <= add_parity(bv[j]);
      end else begin
        issue <= 1'b0;
      end
      @(negedge clk);
      if (j >= 3) begin
        check_op_result(ops[j-3], av[j-3], bv[j-3]);
      end else begin
        check_flag(ret_en, 1'b0, "ret_en before first result");
      end
    end
  endtask

  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    stop_run();
  end

  initial begin
    issue = 1'b0;
    op = OP_ADD32;
    opnd_a = '0;
    opnd_b = '0;
    fwd_bus = '0;
    sel_a = '0;
    sel_b = '0;
    late_a = 1'b0;
    late_b = 1'b0;
    alt_sel = 2'b00;
    alt_data0 = '0;
    alt_data1 = '0;
    @(negedge rst);
    @(negedge clk);
    check_flag(bus_valid, 1'b0, "bus_valid after reset");
    check_flag(ret_en, 1'b0, "ret_en after reset");
    alu_test();
    permute_test();
    forwarding_test();
    status_test();
    priority_test();
    back_to_back_test();
    $display("Test passed");
    $finish;
  end

endmodule

//--- all.f
verilog/simd_pkg.sv
verilog/operand_forward.sv
verilog/op_decode.sv
verilog/simd_alu_lane.sv
verilog/permute_lane.sv
verilog/result_bus_arbiter.sv
verilog/simd_unit.sv
dv/tb_clock.sv
dv/simd_unit_tb.sv
